// ==== files.f ====
+incdir+verif
src/cpu_pkg.sv
src/fetch_stage.sv
src/inst_decoder.sv
src/reg_file.sv
src/id_ex_reg.sv
src/exec_unit.sv
src/core_top.sv
verif/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module core_tb -o core_tb_sim

./obj_dir/core_tb_sim | tee sim.log

# the run counts as passed only if the pass line is in the log
grep -q "^Test completed successfully$" sim.log
echo "simulation passed"

// ==== src/core_top.sv ====
module core_top
    import cpu_pkg::*;
#(
    parameter data_t RESET_PC = 32'h0000_0000
) (
    input  logic      clk,
    input  logic      rst_i,
    // instruction port
    output data_t     imem_addr_o,
    input  instr_t    imem_data_i,
    // writeback trace
    output logic      wb_valid_o,
    output reg_addr_t wb_rd_o,
    output data_t     wb_data_o
);

    // fetch and decode
    data_t         if_pc;
    instr_t        if_instr;
    data_t         id_pc_next;
    reg_addr_t     id_rs1;
    reg_addr_t     id_rs2;
    reg_addr_t     id_rd;
    data_t         id_imm;
    data_t         id_rs1_data;
    data_t         id_rs2_data;
    logic          id_jump;
    logic          id_branch;
    logic          id_jalr;
    logic          id_reg_write;
    alu_src1_sel_t id_src1_sel;
    alu_src2_sel_t id_src2_sel;
    alu_op_t       id_alu_op;
    cmp_op_t       id_cmp_op;
    wb_data_sel_t  id_wb_sel;

    // execute
    data_t         ex_pc;
    data_t         ex_pc_next;
    data_t         ex_rs1_data;
    data_t         ex_rs2_data;
    data_t         ex_imm;
    logic          ex_jump;
    logic          ex_branch;
    logic          ex_jalr;
    logic          ex_reg_write;
    alu_src1_sel_t ex_src1_sel;
    alu_src2_sel_t ex_src2_sel;
    alu_op_t       ex_alu_op;
    cmp_op_t       ex_cmp_op;
    wb_data_sel_t  ex_wb_sel;
    reg_addr_t     ex_rd;
    reg_addr_t     ex_rs1;
    reg_addr_t     ex_rs2;
    logic          redirect;
    data_t         redirect_pc;

    // return address for jal and jalr
    assign id_pc_next = if_pc + 32'd4;

    fetch_stage #(
        .RESET_PC(RESET_PC)
    ) u_fetch (
        .clk          (clk),
        .rst_i        (rst_i),
        .redirect_i   (redirect),
        .redirect_pc_i(redirect_pc),
        .imem_data_i  (imem_data_i),
        .imem_addr_o  (imem_addr_o),
        .if_pc_o      (if_pc),
        .if_instr_o   (if_instr)
    );

    inst_decoder u_decoder (
        .instr_i       (if_instr),
        .rs1_o         (id_rs1),
        .rs2_o         (id_rs2),
        .rd_o          (id_rd),
        .imm_o         (id_imm),
        .jump_o        (id_jump),
        .branch_o      (id_branch),
        .jalr_o        (id_jalr),
        .reg_write_o   (id_reg_write),
        .alu_src1_sel_o(id_src1_sel),
        .alu_src2_sel_o(id_src2_sel),
        .alu_op_o      (id_alu_op),
        .cmp_op_o      (id_cmp_op),
        .wb_data_sel_o (id_wb_sel)
    );

    reg_file u_regs (
        .clk     (clk),
        .rst_i   (rst_i),
        .raddr1_i(id_rs1),
        .raddr2_i(id_rs2),
        .rdata1_o(id_rs1_data),
        .rdata2_o(id_rs2_data),
        .we_i    (wb_valid_o),
        .waddr_i (wb_rd_o),
        .wdata_i (wb_data_o)
    );

    id_ex_reg u_id_ex (
        .clk           (clk),
        .rst_i         (rst_i),
        .flush_i       (redirect),
        .pc_i          (if_pc),
        .pc_next_i     (id_pc_next),
        .rs1_data_i    (id_rs1_data),
        .rs2_data_i    (id_rs2_data),
        .imm_i         (id_imm),
        .jump_i        (id_jump),
        .branch_i      (id_branch),
        .jalr_i        (id_jalr),
        .reg_write_i   (id_reg_write),
        .alu_src1_sel_i(id_src1_sel),
        .alu_src2_sel_i(id_src2_sel),
        .alu_op_i      (id_alu_op),
        .cmp_op_i      (id_cmp_op),
        .wb_data_sel_i (id_wb_sel),
        .rd_i          (id_rd),
        .rs1_i         (id_rs1),
        .rs2_i         (id_rs2),
        .pc_o          (ex_pc),
        .pc_next_o     (ex_pc_next),
        .rs1_data_o    (ex_rs1_data),
        .rs2_data_o    (ex_rs2_data),
        .imm_o         (ex_imm),
        .jump_o        (ex_jump),
        .branch_o      (ex_branch),
        .jalr_o        (ex_jalr),
        .reg_write_o   (ex_reg_write),
        .alu_src1_sel_o(ex_src1_sel),
        .alu_src2_sel_o(ex_src2_sel),
        .alu_op_o      (ex_alu_op),
        .cmp_op_o      (ex_cmp_op),
        .wb_data_sel_o (ex_wb_sel),
        .rd_o          (ex_rd),
        .rs1_o         (ex_rs1),
        .rs2_o         (ex_rs2)
    );

    exec_unit u_exec (
        .clk           (clk),
        .rst_i         (rst_i),
        .pc_i          (ex_pc),
        .pc_next_i     (ex_pc_next),
        .rs1_data_i    (ex_rs1_data),
        .rs2_data_i    (ex_rs2_data),
        .imm_i         (ex_imm),
        .jump_i        (ex_jump),
        .branch_i      (ex_branch),
        .jalr_i        (ex_jalr),
        .reg_write_i   (ex_reg_write),
        .alu_src1_sel_i(ex_src1_sel),
        .alu_src2_sel_i(ex_src2_sel),
        .alu_op_i      (ex_alu_op),
        .cmp_op_i      (ex_cmp_op),
        .wb_data_sel_i (ex_wb_sel),
        .rd_i          (ex_rd),
        .rs1_i         (ex_rs1),
        .rs2_i         (ex_rs2),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .wb_we_o       (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

endmodule

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

    // basic widths
    typedef logic [31:0] data_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [31:0] instr_t;

    // control codes
    typedef logic [3:0] alu_op_t;
    typedef logic [2:0] cmp_op_t;
    typedef logic [1:0] alu_src1_sel_t;
    typedef logic       alu_src2_sel_t;
    typedef logic       wb_data_sel_t;

    localparam alu_op_t ALU_ADD  = 4'd0;
    localparam alu_op_t ALU_SUB  = 4'd1;
    localparam alu_op_t ALU_SLL  = 4'd2;
    localparam alu_op_t ALU_SLT  = 4'd3;
    localparam alu_op_t ALU_SLTU = 4'd4;
    localparam alu_op_t ALU_XOR  = 4'd5;
    localparam alu_op_t ALU_SRL  = 4'd6;
    localparam alu_op_t ALU_SRA  = 4'd7;
    localparam alu_op_t ALU_OR   = 4'd8;
    localparam alu_op_t ALU_AND  = 4'd9;

    // same values as the branch funct3 field
    localparam cmp_op_t CMP_EQ  = 3'b000;
    localparam cmp_op_t CMP_NE  = 3'b001;
    localparam cmp_op_t CMP_LT  = 3'b100;
    localparam cmp_op_t CMP_GE  = 3'b101;
    localparam cmp_op_t CMP_LTU = 3'b110;
    localparam cmp_op_t CMP_GEU = 3'b111;

    localparam alu_src1_sel_t SRC1_RS1  = 2'd0;
    localparam alu_src1_sel_t SRC1_PC   = 2'd1;
    localparam alu_src1_sel_t SRC1_ZERO = 2'd2;

    localparam alu_src2_sel_t SRC2_RS2 = 1'b0;
    localparam alu_src2_sel_t SRC2_IMM = 1'b1;

    localparam wb_data_sel_t WB_ALU     = 1'b0;
    localparam wb_data_sel_t WB_PC_NEXT = 1'b1;

    // addi x0, x0, 0
    localparam instr_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== src/exec_unit.sv ====
module exec_unit
    import cpu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_i,
    input  data_t         pc_i,
    input  data_t         pc_next_i,
    input  data_t         rs1_data_i,
    input  data_t         rs2_data_i,
    input  data_t         imm_i,
    input  logic          jump_i,
    input  logic          branch_i,
    input  logic          jalr_i,
    input  logic          reg_write_i,
    input  alu_src1_sel_t alu_src1_sel_i,
    input  alu_src2_sel_t alu_src2_sel_i,
    input  alu_op_t       alu_op_i,
    input  cmp_op_t       cmp_op_i,
    input  wb_data_sel_t  wb_data_sel_i,
    input  reg_addr_t     rd_i,
    input  reg_addr_t     rs1_i,
    input  reg_addr_t     rs2_i,
    output logic          redirect_o,
    output data_t         redirect_pc_o,
    output logic          wb_we_o,
    output reg_addr_t     wb_rd_o,
    output data_t         wb_data_o
);

    data_t op_a;
    data_t op_b;
    data_t alu_result;
    logic  cmp_true;

    // operand selection
    always_comb begin
        case (alu_src1_sel_i)
            SRC1_RS1: op_a = rs1_data_i;
            SRC1_PC:  op_a = pc_i;
            default:  op_a = '0;
        endcase
        op_b = (alu_src2_sel_i == SRC2_IMM) ? imm_i : rs2_data_i;
    end

    always_comb begin
        case (alu_op_i)
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = data_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_result = op_a | op_b;
            ALU_AND:  alu_result = op_a & op_b;
            default:  alu_result = op_a + op_b;
        endcase
    end

    // branch compare always on the two register values
    always_comb begin
        case (cmp_op_i)
            CMP_EQ:  cmp_true = (rs1_data_i == rs2_data_i);
            CMP_NE:  cmp_true = (rs1_data_i != rs2_data_i);
            CMP_LT:  cmp_true = ($signed(rs1_data_i) < $signed(rs2_data_i));
            CMP_GE:  cmp_true = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            CMP_LTU: cmp_true = (rs1_data_i < rs2_data_i);
            CMP_GEU: cmp_true = (rs1_data_i >= rs2_data_i);
            default: cmp_true = 1'b0;
        endcase
    end

    assign redirect_o    = jump_i || (branch_i && cmp_true);
    assign redirect_pc_o = jalr_i ? ((rs1_data_i + imm_i) & ~32'd1) : (pc_i + imm_i);

    // no retire for x0 destinations
    assign wb_we_o   = reg_write_i && (rd_i != '0);
    assign wb_rd_o   = rd_i;
    assign wb_data_o = (wb_data_sel_i == WB_PC_NEXT) ? pc_next_i : alu_result;

    a_one_kind_of_jump: assert property (@(posedge clk) disable iff (rst_i)
        !(jump_i && branch_i));

    // operands from x0 arrive as zero through decode and the pipeline
    a_x0_operands: assert property (@(posedge clk) disable iff (rst_i)
        ((rs1_i == '0) |-> (rs1_data_i == '0)) and ((rs2_i == '0) |-> (rs2_data_i == '0)));

endmodule

// ==== src/fetch_stage.sv ====
module fetch_stage
    import cpu_pkg::*;
#(
    parameter data_t RESET_PC = 32'h0000_0000
) (
    input  logic   clk,
    input  logic   rst_i,
    // redirect from execute
    input  logic   redirect_i,
    input  data_t  redirect_pc_i,
    // instruction port
    input  instr_t imem_data_i,
    output data_t  imem_addr_o,
    // IF/ID contents
    output data_t  if_pc_o,
    output instr_t if_instr_o
);

    data_t pc_q;

    // program counter
    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign imem_addr_o = pc_q;

    // IF/ID register, a redirect kills the word fetched this cycle
    always_ff @(posedge clk) begin
        if (rst_i || redirect_i) begin
            if_instr_o <= NOP_INSTR;
        end else begin
            if_instr_o <= imem_data_i;
        end
    end

    always_ff @(posedge clk) begin
        if_pc_o <= pc_q;
    end

endmodule

// ==== src/id_ex_reg.sv ====
module id_ex_reg
    import cpu_pkg::*;
(
    input  logic          clk,
    input  logic          rst_i,
    input  logic          flush_i,
    // data
    input  data_t         pc_i,
    input  data_t         pc_next_i,
    input  data_t         rs1_data_i,
    input  data_t         rs2_data_i,
    input  data_t         imm_i,
    // control
    input  logic          jump_i,
    input  logic          branch_i,
    input  logic          jalr_i,
    input  logic          reg_write_i,
    input  alu_src1_sel_t alu_src1_sel_i,
    input  alu_src2_sel_t alu_src2_sel_i,
    input  alu_op_t       alu_op_i,
    input  cmp_op_t       cmp_op_i,
    input  wb_data_sel_t  wb_data_sel_i,
    // register addresses
    input  reg_addr_t     rd_i,
    input  reg_addr_t     rs1_i,
    input  reg_addr_t     rs2_i,
    output data_t         pc_o,
    output data_t         pc_next_o,
    output data_t         rs1_data_o,
    output data_t         rs2_data_o,
    output data_t         imm_o,
    output logic          jump_o,
    output logic          branch_o,
    output logic          jalr_o,
    output logic          reg_write_o,
    output alu_src1_sel_t alu_src1_sel_o,
    output alu_src2_sel_t alu_src2_sel_o,
    output alu_op_t       alu_op_o,
    output cmp_op_t       cmp_op_o,
    output wb_data_sel_t  wb_data_sel_o,
    output reg_addr_t     rd_o,
    output reg_addr_t     rs1_o,
    output reg_addr_t     rs2_o
);

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            // bubble with every enable off
            pc_o           <= '0;
            pc_next_o      <= '0;
            rs1_data_o     <= '0;
            rs2_data_o     <= '0;
            imm_o          <= '0;
            jump_o         <= 1'b0;
            branch_o       <= 1'b0;
            jalr_o         <= 1'b0;
            reg_write_o    <= 1'b0;
            alu_src1_sel_o <= SRC1_RS1;
            alu_src2_sel_o <= SRC2_RS2;
            alu_op_o       <= ALU_ADD;
            cmp_op_o       <= CMP_EQ;
            wb_data_sel_o  <= WB_ALU;
            rd_o           <= '0;
            rs1_o          <= '0;
            rs2_o          <= '0;
        end else begin
            pc_o           <= pc_i;
            pc_next_o      <= pc_next_i;
            rs1_data_o     <= rs1_data_i;
            rs2_data_o     <= rs2_data_i;
            imm_o          <= imm_i;
            jump_o         <= jump_i;
            branch_o       <= branch_i;
            jalr_o         <= jalr_i;
            reg_write_o    <= reg_write_i;
            alu_src1_sel_o <= alu_src1_sel_i;
            alu_src2_sel_o <= alu_src2_sel_i;
            alu_op_o       <= alu_op_i;
            cmp_op_o       <= cmp_op_i;
            wb_data_sel_o  <= wb_data_sel_i;
            rd_o           <= rd_i;
            rs1_o          <= rs1_i;
            rs2_o          <= rs2_i;
        end
    end

    a_flush_kills: assert property (@(posedge clk)
        (rst_i || flush_i) |=> (!reg_write_o && !jump_o));

endmodule

// ==== src/inst_decoder.sv ====
module inst_decoder
    import cpu_pkg::*;
(
    input  instr_t        instr_i,
    output reg_addr_t     rs1_o,
    output reg_addr_t     rs2_o,
    output reg_addr_t     rd_o,
    output data_t         imm_o,
    output logic          jump_o,
    output logic          branch_o,
    output logic          jalr_o,
    output logic          reg_write_o,
    output alu_src1_sel_t alu_src1_sel_o,
    output alu_src2_sel_t alu_src2_sel_o,
    output alu_op_t       alu_op_o,
    output cmp_op_t       cmp_op_o,
    output wb_data_sel_t  wb_data_sel_o
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    data_t      imm_i_type;
    data_t      imm_u_type;
    data_t      imm_b_type;
    data_t      imm_j_type;
    alu_op_t    arith_op;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    // immediate formats
    assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_u_type = {instr_i[31:12], 12'b0};
    assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

    // funct3 to ALU op, bit 30 picks sub only for register ops
    always_comb begin
        case (funct3)
            3'b000:  arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        // bubble unless the opcode says otherwise
        imm_o          = imm_i_type;
        jump_o         = 1'b0;
        branch_o       = 1'b0;
        jalr_o         = 1'b0;
        reg_write_o    = 1'b0;
        alu_src1_sel_o = SRC1_RS1;
        alu_src2_sel_o = SRC2_RS2;
        alu_op_o       = ALU_ADD;
        cmp_op_o       = funct3;
        wb_data_sel_o  = WB_ALU;
        case (opcode)
            OPC_OP: begin
                reg_write_o = 1'b1;
                alu_op_o    = arith_op;
            end
            OPC_OP_IMM: begin
                reg_write_o    = 1'b1;
                alu_src2_sel_o = SRC2_IMM;
                alu_op_o       = arith_op;
            end
            OPC_LUI, OPC_AUIPC: begin
                imm_o          = imm_u_type;
                reg_write_o    = 1'b1;
                alu_src1_sel_o = (opcode == OPC_LUI) ? SRC1_ZERO : SRC1_PC;
                alu_src2_sel_o = SRC2_IMM;
            end
            OPC_JAL, OPC_JALR: begin
                imm_o         = (opcode == OPC_JAL) ? imm_j_type : imm_i_type;
                jump_o        = 1'b1;
                jalr_o        = (opcode == OPC_JALR);
                reg_write_o   = 1'b1;
                wb_data_sel_o = WB_PC_NEXT;
            end
            OPC_BRANCH: begin
                imm_o = imm_b_type;
                // funct3 010 and 011 are not branches
                branch_o = (funct3[2:1] != 2'b01);
            end
            default: ;
        endcase
    end

endmodule

// ==== src/reg_file.sv ====
module reg_file
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_i,
    input  reg_addr_t raddr1_i,
    input  reg_addr_t raddr2_i,
    output data_t     rdata1_o,
    output data_t     rdata2_o,
    input  logic      we_i,
    input  reg_addr_t waddr_i,
    input  data_t     wdata_i
);

    data_t regs [32];
    logic  wr_en;

    // x0 is never stored
    assign wr_en = we_i && !rst_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        if (wr_en) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so decode sees the value retiring this cycle
    always_comb begin
        rdata1_o = regs[raddr1_i];
        if (wr_en && waddr_i == raddr1_i) begin
            rdata1_o = wdata_i;
        end
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end
        rdata2_o = regs[raddr2_i];
        if (wr_en && waddr_i == raddr2_i) begin
            rdata2_o = wdata_i;
        end
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end
    end

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (rst_i)
        ((raddr1_i == '0) |-> (rdata1_o == '0)) and ((raddr2_i == '0) |-> (rdata2_o == '0)));

endmodule

// ==== verif/rv_ref_model.svh ====
// ALU result of the ISA, alt selects sub or sra
function automatic data_t alu_ref(input logic [2:0] f3, input logic alt, input data_t a,
                                  input data_t b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic bit branch_ref(input logic [2:0] f3, input data_t a, input data_t b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// runs the ROM from RESET_PC up to the self-loop, returns the write count
function automatic int rv_ref_run();
    data_t      regs [32];
    data_t      pc;
    data_t      next_pc;
    data_t      off;
    data_t      a;
    data_t      b;
    data_t      imm_i;
    data_t      result;
    instr_t     ins;
    logic [2:0] f3;
    logic       wr;
    int         n;
    n = 0;
    pc = RESET_PC;
    for (int i = 0; i < 32; i++) begin
        regs[i] = '0;
    end
    for (int step = 0; step < MAX_STEPS; step++) begin
        off = pc - RESET_PC;
        ins = rom[off[9:2]];
        if (ins == JAL_SELF) begin
            break;
        end
        a = regs[ins[19:15]];
        b = regs[ins[24:20]];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        next_pc = pc + 32'd4;
        wr = 1'b1;
        result = '0;
        case (ins[6:0])
            OPC_OP:     result = alu_ref(f3, ins[30], a, b);
            OPC_OP_IMM: result = alu_ref(f3, (f3 == 3'b101) && ins[30], a, imm_i);
            OPC_LUI:    result = {ins[31:12], 12'b0};
            OPC_AUIPC:  result = pc + {ins[31:12], 12'b0};
            OPC_JAL: begin
                result = pc + 32'd4;
                next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OPC_JALR: begin
                result = pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                wr = 1'b0;
                if (branch_ref(f3, a, b)) begin
                    next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: wr = 1'b0;
        endcase
        // x0 stays zero and is never traced
        if (wr && ins[11:7] != 5'd0 && n < MAX_WRITES) begin
            regs[ins[11:7]] = result;
            exp_rd[n] = ins[11:7];
            exp_data[n] = result;
            n++;
        end
        pc = next_pc;
    end
    return n;
endfunction

// ==== verif/core_tb.sv ====
module core_tb
    import cpu_pkg::*;
();

    localparam data_t      RESET_PC   = 32'h0000_0200;
    localparam instr_t     JAL_SELF   = 32'h0000_006f;
    localparam int         MAX_STEPS  = 4096;
    localparam int         MAX_WRITES = 256;
    localparam int         WAIT_LIMIT = 2000;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    logic      clk;
    logic      rst_i;
    data_t     imem_addr;
    instr_t    imem_data;
    logic      wb_valid;
    reg_addr_t wb_rd;
    data_t     wb_data;
    data_t     rom_off;

    instr_t    rom [256];
    reg_addr_t exp_rd [MAX_WRITES];
    data_t     exp_data [MAX_WRITES];
    int        exp_total;
    int        got_count = 0;
    int        err_count = 0;
    int        timeout_count;
    int        prog_len;
    int        pass_tests;
    int        fail_tests;
    string     test_name;

    `include "rv_ref_model.svh"

    core_top #(
        .RESET_PC(RESET_PC)
    ) uut (
        .clk        (clk),
        .rst_i      (rst_i),
        .imem_addr_o(imem_addr),
        .imem_data_i(imem_data),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data)
    );

    // program ROM answers in the same cycle
    assign rom_off   = imem_addr - RESET_PC;
    assign imem_data = rom[rom_off[9:2]];

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // trace compare against the reference sequence
    always @(posedge clk) begin
        if (rst_i) begin
            got_count = 0;
        end else if (wb_valid) begin
            if (got_count >= exp_total) begin
                $display("%s: unexpected write x%0d = %08h beyond %0d expected writes",
                         test_name, wb_rd, wb_data, exp_total);
                err_count++;
            end else begin
                if (wb_rd != exp_rd[got_count]) begin
                    $display("[ERROR] %s: write %0d rd expected x%0d actual x%0d",
                             test_name, got_count, exp_rd[got_count], wb_rd);
                    err_count++;
                end
                if (wb_data != exp_data[got_count]) begin
                    $display("[ERROR] %s: write %0d data expected %08h actual %08h",
                             test_name, got_count, exp_data[got_count], wb_data);
                    err_count++;
                end
            end
            got_count++;
        end
    end

    function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t enc_u(input logic [19:0] imm, input reg_addr_t rd,
                                     input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic instr_t enc_b(input logic [12:0] off, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic instr_t enc_j(input logic [20:0] off, input reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // programs only touch x1 to x7 so dependencies are frequent
    function automatic reg_addr_t rand_reg();
        return reg_addr_t'($urandom_range(7, 1));
    endfunction

    task automatic emit(input instr_t word);
        rom[prog_len] = word;
        prog_len++;
    endtask

    // register file has no reset, so programs set x1 to x7 first
    task automatic start_program(input bit with_init);
        for (int i = 0; i < 256; i++) begin
            rom[i] = NOP_INSTR;
        end
        prog_len = 0;
        if (with_init) begin
            for (int r = 1; r < 8; r++) begin
                emit(enc_u(20'($urandom), reg_addr_t'(r), OPC_LUI));
                emit(enc_i(12'($urandom), reg_addr_t'(r), 3'b000, reg_addr_t'(r), OPC_OP_IMM));
            end
        end
    endtask

    task automatic gen_imm_alu();
        logic [2:0]  f3;
        logic [11:0] imm;
        start_program(1'b1);
        repeat (24) begin
            f3 = 3'($urandom);
            imm = 12'($urandom);
            if ($urandom_range(3, 0) == 0) begin
                emit(enc_u(20'($urandom), rand_reg(), OPC_LUI));
            end else begin
                // shifts carry shamt and the srai bit only
                if (f3 == 3'b001) begin
                    imm = {7'b0, imm[4:0]};
                end
                if (f3 == 3'b101) begin
                    imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                end
                emit(enc_i(imm, rand_reg(), f3, rand_reg(), OPC_OP_IMM));
            end
        end
        emit(JAL_SELF);
    endtask

    task automatic gen_reg_chain();
        logic [2:0] f3;
        logic [6:0] f7;
        reg_addr_t  prev;
        reg_addr_t  rd;
        start_program(1'b1);
        prev = 5'd1;
        repeat (24) begin
            f3 = 3'($urandom);
            rd = rand_reg();
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(1, 0) == 1) ? 7'h20 : 7'h00;
            // each op reads the result retiring right before it
            if ($urandom_range(1, 0) == 1) begin
                emit(enc_r(f7, prev, prev, f3, rd));
            end else begin
                emit(enc_r(f7, rand_reg(), prev, f3, rd));
            end
            prev = rd;
        end
        emit(JAL_SELF);
    endtask

    task automatic gen_branches();
        logic [2:0] f3;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        start_program(1'b1);
        for (int k = 0; k < 6; k++) begin
            f3 = 3'((k < 2) ? k : k + 2);
            // operand pairs (x1,x2), (x2,x1) and (x3,x3)
            for (int p = 0; p < 3; p++) begin
                rs1 = reg_addr_t'((p == 1) ? 2 : p + 1);
                rs2 = reg_addr_t'((p == 0) ? 2 : ((p == 1) ? 1 : 3));
                emit(enc_b(13'd12, rs2, rs1, f3));
                emit(enc_i(12'd1, 5'd4, 3'b000, 5'd4, OPC_OP_IMM));
                emit(enc_i(12'd1, 5'd5, 3'b000, 5'd5, OPC_OP_IMM));
                emit(enc_i(12'd3, 5'd6, 3'b000, 5'd6, OPC_OP_IMM));
            end
        end
        emit(JAL_SELF);
    endtask

    task automatic gen_jumps();
        reg_addr_t link;
        start_program(1'b0);
        repeat (4) begin
            link = rand_reg();
            emit(enc_j(21'd12, link));
            emit(enc_i(12'd1, 5'd0, 3'b000, 5'd4, OPC_OP_IMM));
            emit(enc_i(12'd2, 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
            emit(enc_i(12'd0, link, 3'b000, 5'd6, OPC_OP_IMM));
            // jalr lands 16 bytes past the auipc, the odd bit is dropped
            emit(enc_u(20'd0, 5'd2, OPC_AUIPC));
            emit(enc_i(12'd17, 5'd2, 3'b000, 5'd3, OPC_JALR));
            emit(enc_i(12'd3, 5'd0, 3'b000, 5'd4, OPC_OP_IMM));
            emit(enc_i(12'd4, 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
            emit(enc_i(12'd0, 5'd3, 3'b000, 5'd7, OPC_OP_IMM));
        end
        emit(JAL_SELF);
    endtask

    task automatic gen_auipc_x0();
        start_program(1'b1);
        repeat (6) begin
            emit(enc_u(20'($urandom), rand_reg(), OPC_AUIPC));
            // writes to x0 never retire
            emit(enc_i(12'($urandom), rand_reg(), 3'b000, 5'd0, OPC_OP_IMM));
            emit(enc_r(7'd0, rand_reg(), rand_reg(), 3'b000, 5'd0));
            emit(enc_u(20'($urandom), 5'd0, OPC_LUI));
            // reads of x0
            emit(enc_r(7'd0, rand_reg(), 5'd0, 3'b110, rand_reg()));
            emit(enc_i(12'($urandom), 5'd0, 3'b100, rand_reg(), OPC_OP_IMM));
        end
        emit(enc_j(21'd4, 5'd0));
        emit(JAL_SELF);
    endtask

    task automatic enter_reset();
        @(negedge clk);
        rst_i = 1'b1;
    endtask

    task automatic leave_reset();
        repeat (4) @(negedge clk);
        // fetch address sits at the reset vector while reset is held
        if (imem_addr != RESET_PC) begin
            $display("[ERROR] %s: fetch address in reset expected %08h actual %08h",
                     test_name, RESET_PC, imem_addr);
            err_count++;
        end
        rst_i = 1'b0;
    endtask

    task automatic wait_writes(input int n);
        int cycles;
        cycles = 0;
        while (got_count < n && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (got_count < n) begin
            $display("%s: timed out after %0d cycles with %0d of %0d writes retired",
                     test_name, cycles, got_count, n);
            timeout_count++;
        end
    endtask

    // called with rst_i high and the program loaded
    task automatic run_test(input string name, input int early);
        int errs_before;
        int timeouts_before;
        test_name = name;
        exp_total = rv_ref_run();
        errs_before = err_count;
        timeouts_before = timeout_count;
        leave_reset();
        if (early > 0) begin
            wait_writes(early);
            enter_reset();
            leave_reset();
        end
        wait_writes(exp_total);
        // a write in this window is an extra one
        repeat (20) @(negedge clk);
        if (err_count == errs_before && timeout_count == timeouts_before) begin
            pass_tests++;
            $display("PASS %s: %0d writes retired", name, exp_total);
        end else begin
            fail_tests++;
            $display("FAIL %s: %0d mismatches, %0d timeouts", name,
                     err_count - errs_before, timeout_count - timeouts_before);
        end
    endtask

    initial begin
        rst_i = 1'b1;
        pass_tests = 0;
        fail_tests = 0;
        timeout_count = 0;
        exp_total = 0;
        test_name = "startup";
        void'($urandom(32'h632bb6bf));
        start_program(1'b0);

        enter_reset();
        gen_imm_alu();
        run_test("imm_alu", 0);
        enter_reset();
        gen_reg_chain();
        run_test("reg_chain", 0);
        enter_reset();
        gen_branches();
        run_test("branches", 0);
        enter_reset();
        gen_jumps();
        run_test("jumps", 0);
        enter_reset();
        gen_auipc_x0();
        run_test("auipc_x0", 0);
        enter_reset();
        gen_reg_chain();
        run_test("reset_mid_program", 20);

        $display("%0d tests passed, %0d tests failed", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
